/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rw_generator
LINT_TOP  ?= rw_generator_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* rw_control.sv */
// Setup and run FSM that holds the configuration and strobes done at run end
`timescale 1ns/100ps

module rw_control import rw_gen_pkg::*; (
    input  logic                        ap_clk,
    input  logic                        areset_generator,
    input  logic                        descriptor_valid,
    input  logic                        config_valid,
    input  rw_config_t                  config_in,
    input  logic [rw_count_w-1:0]       issued_count,
    input  logic                        in_flight,
    input  logic [rw_outstanding_w-1:0] outstanding,
    output logic                        config_request,
    output logic                        active,
    output rw_config_t                  run_config,
    output logic                        clear,
    output logic                        busy,
    output logic                        done
);

    // --------------------
    // Signals
    // --------------------
    rw_ctrl_state_t state;
    rw_ctrl_state_t next_state;
    logic           config_accept;
    logic           all_issued;
    logic           run_complete;

    assign config_accept = (state == rw_ctrl_config_wait) && config_valid;

    // Issued count still holds the last run's value while clear is high
    assign all_issued = !clear && (issued_count == run_config.word_count);

    // Pipeline empty and in read mode every response back
    assign run_complete = !in_flight &&
                          ((run_config.mode == rw_mode_write) || (outstanding == '0));

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            rw_ctrl_idle: begin
                if (descriptor_valid) begin
                    next_state = rw_ctrl_config_request;
                end
            end
            rw_ctrl_config_request: begin
                next_state = rw_ctrl_config_wait;
            end
            rw_ctrl_config_wait: begin
                if (config_valid) begin
                    next_state = rw_ctrl_busy;
                end
            end
            rw_ctrl_busy: begin
                if (all_issued) begin
                    next_state = rw_ctrl_drain;
                end
            end
            rw_ctrl_drain: begin
                if (run_complete) begin
                    next_state = rw_ctrl_idle;
                end
            end
            default: begin
                next_state = rw_ctrl_idle;
            end
        endcase
    end

    // --------------------
    // State and strobes
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= rw_ctrl_idle;
            clear <= 1'b0;
            done  <= 1'b0;
        end
        else begin
            state <= next_state;
            clear <= config_accept;
            done  <= (state == rw_ctrl_drain) && run_complete;
        end
    end

    // Held for the whole run
    always_ff @(posedge ap_clk) begin
        if (config_accept) begin
            run_config <= config_in;
        end
    end

    // Busy drops in the cycle that done rises
    assign config_request = (state == rw_ctrl_config_request);
    assign active         = (state == rw_ctrl_busy);
    assign busy           = (state == rw_ctrl_busy) || (state == rw_ctrl_drain);

    // A new setup never starts in the cycle a run finishes
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(done && config_request));

endmodule : rw_control

/* rw_gen_pkg.sv */
// Read/write generator shared widths, payload structs and controller states

package rw_gen_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int rw_addr_w        = 32;
    localparam int rw_data_w        = 32;
    localparam int rw_count_w       = 16;
    localparam int rw_outstanding_w = 8;

    // Top value of the outstanding-read counter
    localparam int rw_max_outstanding = 255;

    // --------------------
    // Run configuration
    // --------------------
    typedef enum logic [0:0] {
        rw_mode_read  = 1'b0,
        rw_mode_write = 1'b1
    } rw_mode_t;

    // Address of word n is base_address + n * stride
    typedef struct packed {
        rw_mode_t                mode;
        logic [rw_addr_w-1:0]    base_address;
        logic [rw_addr_w-1:0]    stride;
        logic [rw_count_w-1:0]   word_count;
    } rw_config_t;

    // --------------------
    // Memory side payloads
    // --------------------
    // Read requests carry zero data
    typedef struct packed {
        logic                    is_write;
        logic [rw_addr_w-1:0]    address;
        logic [rw_data_w-1:0]    data;
    } rw_mem_request_t;

    // Returned to the engine unchanged
    typedef struct packed {
        logic [rw_addr_w-1:0]    address;
        logic [rw_data_w-1:0]    data;
    } rw_mem_response_t;

    // --------------------
    // Controller FSM
    // --------------------
    // Setup, then busy while words are accepted, then drain until the run is complete
    typedef enum logic [2:0] {
        rw_ctrl_idle           = 3'd0,
        rw_ctrl_config_request = 3'd1,
        rw_ctrl_config_wait    = 3'd2,
        rw_ctrl_busy           = 3'd3,
        rw_ctrl_drain          = 3'd4
    } rw_ctrl_state_t;

endpackage : rw_gen_pkg

/* rw_generator_top.sv */
// Read/write request generator for one engine lane
`timescale 1ns/100ps

module rw_generator_top import rw_gen_pkg::*; (
    input  logic                 ap_clk,
    input  logic                 areset_generator,
    input  logic                 descriptor_valid,
    output logic                 config_request,
    input  logic                 config_valid,
    input  rw_config_t           config_in,
    input  logic                 engine_valid,
    input  logic [rw_data_w-1:0] engine_data,
    output logic                 mem_request_valid,
    output rw_mem_request_t      mem_request,
    input  logic                 mem_response_valid,
    input  rw_mem_response_t     mem_response,
    output logic                 engine_response_valid,
    output rw_mem_response_t     engine_response,
    output logic                 busy,
    output logic                 done
);

    // --------------------
    // Internal wires
    // --------------------
    logic                        active;
    rw_config_t                  run_config;
    logic                        clear;
    logic [rw_count_w-1:0]       issued_count;
    logic                        in_flight;
    logic [rw_outstanding_w-1:0] outstanding;
    logic                        read_issued;

    // Only reads expect a response
    assign read_issued = mem_request_valid && !mem_request.is_write;

    rw_control control_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .descriptor_valid (descriptor_valid),
        .config_valid     (config_valid),
        .config_in        (config_in),
        .issued_count     (issued_count),
        .in_flight        (in_flight),
        .outstanding      (outstanding),
        .config_request   (config_request),
        .active           (active),
        .run_config       (run_config),
        .clear            (clear),
        .busy             (busy),
        .done             (done)
    );

    rw_request_gen request_gen_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .active           (active),
        .run_config       (run_config),
        .clear            (clear),
        .engine_valid     (engine_valid),
        .engine_data      (engine_data),
        .request_valid    (mem_request_valid),
        .request          (mem_request),
        .issued_count     (issued_count),
        .in_flight        (in_flight)
    );

    rw_response_return response_return_i (
        .ap_clk                (ap_clk),
        .areset_generator      (areset_generator),
        .read_issued           (read_issued),
        .mem_response_valid    (mem_response_valid),
        .mem_response          (mem_response),
        .engine_response_valid (engine_response_valid),
        .engine_response       (engine_response),
        .outstanding           (outstanding)
    );

endmodule : rw_generator_top

/* rw_request_gen.sv */
// Request generation pipeline that turns engine words into addressed memory requests
`timescale 1ns/100ps

module rw_request_gen import rw_gen_pkg::*; (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  logic                  active,
    input  rw_config_t            run_config,
    input  logic                  clear,
    input  logic                  engine_valid,
    input  logic [rw_data_w-1:0]  engine_data,
    output logic                  request_valid,
    output rw_mem_request_t       request,
    output logic [rw_count_w-1:0] issued_count,
    output logic                  in_flight
);

    // --------------------
    // Signals
    // --------------------
    logic [rw_count_w-1:0] accepted_count;
    logic [rw_count_w-1:0] seq_now;
    logic                  accept;

    logic                  s1_valid;
    logic [rw_count_w-1:0] s1_seq;
    logic [rw_data_w-1:0]  s1_data;

    logic                  s2_is_write;
    logic [rw_addr_w-1:0]  s2_address;
    logic [rw_data_w-1:0]  s2_data;

    // --------------------
    // Stage one
    // --------------------
    // A clear in the same cycle as a word restarts the sequence at zero
    assign seq_now = clear ? '0 : accepted_count;

    // Words past word_count are dropped here
    assign accept = engine_valid && active && (seq_now < run_config.word_count);

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            accepted_count <= '0;
            s1_valid       <= 1'b0;
        end
        else begin
            s1_valid <= accept;
            if (accept) begin
                accepted_count <= seq_now + 1'b1;
            end
            else if (clear) begin
                accepted_count <= '0;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (accept) begin
            s1_seq  <= seq_now;
            s1_data <= engine_data;
        end
    end

    // --------------------
    // Stage two
    // --------------------
    assign s2_is_write = (run_config.mode == rw_mode_write);
    assign s2_address  = run_config.base_address + rw_addr_w'(s1_seq) * run_config.stride;
    assign s2_data     = s2_is_write ? s1_data : '0;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            request_valid <= 1'b0;
            issued_count  <= '0;
        end
        else begin
            request_valid <= s1_valid;
            if (clear) begin
                issued_count <= '0;
            end
            else if (s1_valid) begin
                issued_count <= issued_count + 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (s1_valid) begin
            request.is_write <= s2_is_write;
            request.address  <= s2_address;
            request.data     <= s2_data;
        end
    end

    // Either stage still holds a word
    assign in_flight = s1_valid || request_valid;

    // No request leaves without the controller having opened the run
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        request_valid |-> $past(active, 2));

endmodule : rw_request_gen

/* rw_response_return.sv */
// Response return path with one register stage and outstanding-read tracking
`timescale 1ns/100ps

module rw_response_return import rw_gen_pkg::*; (
    input  logic                        ap_clk,
    input  logic                        areset_generator,
    input  logic                        read_issued,
    input  logic                        mem_response_valid,
    input  rw_mem_response_t            mem_response,
    output logic                        engine_response_valid,
    output rw_mem_response_t            engine_response,
    output logic [rw_outstanding_w-1:0] outstanding
);

    // --------------------
    // Engine side register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            engine_response_valid <= 1'b0;
        end
        else begin
            engine_response_valid <= mem_response_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (mem_response_valid) begin
            engine_response <= mem_response;
        end
    end

    // --------------------
    // Outstanding reads
    // --------------------
    // Read out and response back in one cycle cancel out
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            outstanding <= '0;
        end
        else begin
            case ({read_issued, mem_response_valid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // Memory must only answer reads this lane has issued
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        mem_response_valid |-> (outstanding != '0));

    // Counter must not wrap past its top value
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        (outstanding == rw_outstanding_w'(rw_max_outstanding))
            |-> !(read_issued && !mem_response_valid));

endmodule : rw_response_return

/* tb_rw_generator.sv */
// Testbench for the read/write request generator with a queue model and assertions
`timescale 1ns/100ps

module tb_rw_generator import rw_gen_pkg::*; ();

    localparam int timeout_cycles = 4000;
    localparam int run_total      = 4;

    logic                 ap_clk = 1'b0;
    logic                 areset_generator;
    logic                 descriptor_valid;
    logic                 config_request;
    logic                 config_valid;
    rw_config_t           config_in;
    logic                 engine_valid;
    logic [rw_data_w-1:0] engine_data;
    logic                 mem_request_valid;
    rw_mem_request_t      mem_request;
    logic                 mem_response_valid;
    rw_mem_response_t     mem_response;
    logic                 engine_response_valid;
    rw_mem_response_t     engine_response;
    logic                 busy;
    logic                 done;

    // Expected traffic and its head mirrors for the assertions
    rw_mem_request_t      exp_req_q[$];
    rw_mem_response_t     exp_resp_q[$];
    logic [rw_addr_w-1:0] read_addr_q[$];
    int                   read_due_q[$];
    rw_mem_request_t      req_head;
    rw_mem_response_t     resp_head;
    logic                 req_pending;
    logic                 resp_pending;
    logic                 reads_pending;
    logic                 req_seen;
    logic                 resp_seen;
    logic                 word_due;
    logic                 run_open;
    int                   words_left;
    int                   cycle_count = 0;

    always #2 ap_clk = ~ap_clk;

    rw_generator_top dut_i (.*);

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Stopping on the first error");
    endtask

    function automatic void sync_heads();
        req_pending   = (exp_req_q.size() != 0);
        resp_pending  = (exp_resp_q.size() != 0);
        reads_pending = (read_addr_q.size() != 0);
        if (req_pending) begin
            req_head = exp_req_q[0];
        end
        if (resp_pending) begin
            resp_head = exp_resp_q[0];
        end
    endfunction

    // Reads carry no data
    function automatic rw_mem_request_t expected_request(input rw_mode_t mode,
                                                         input logic [rw_addr_w-1:0] addr,
                                                         input logic [rw_data_w-1:0] word);
        rw_mem_request_t req;
        req.is_write = (mode == rw_mode_write);
        req.address  = addr;
        if (mode == rw_mode_write) begin
            req.data = word;
        end
        else begin
            req.data = '0;
        end
        return req;
    endfunction

    // --------------------
    // Memory model stepped once per falling edge
    // --------------------
    task automatic next_cycle();
        rw_mem_request_t  issued;
        rw_mem_response_t answer;
        @(negedge ap_clk);
        // Strobes checked at the last rising edge leave the queues here
        if (req_seen && exp_req_q.size() != 0) begin
            issued = exp_req_q.pop_front();
            if (!issued.is_write) begin
                read_addr_q.push_back(issued.address);
                read_due_q.push_back(cycle_count + int'($urandom_range(0, 5)));
            end
        end
        req_seen = mem_request_valid;
        if (resp_seen && exp_resp_q.size() != 0) begin
            void'(exp_resp_q.pop_front());
        end
        resp_seen = engine_response_valid;
        // Oldest read is answered once its delay is over
        if (read_addr_q.size() != 0 && read_due_q[0] <= cycle_count) begin
            answer.address = read_addr_q.pop_front();
            answer.data    = $urandom();
            void'(read_due_q.pop_front());
            exp_resp_q.push_back(answer);
            mem_response_valid = 1'b1;
            mem_response       = answer;
        end
        else begin
            mem_response_valid = 1'b0;
        end
        sync_heads();
    endtask

    task automatic drive_word(input logic [rw_data_w-1:0] word, input logic counted,
                              input rw_mem_request_t expected);
        engine_valid = 1'b1;
        engine_data  = word;
        word_due     = counted;
        if (counted) begin
            exp_req_q.push_back(expected);
            words_left = words_left - 1;
            sync_heads();
        end
        next_cycle();
        engine_valid = 1'b0;
        word_due     = 1'b0;
    endtask

    task automatic run_once(input rw_mode_t mode);
        rw_config_t           cfg;
        logic [rw_data_w-1:0] word;
        logic [rw_addr_w-1:0] addr;
        cfg.mode         = mode;
        cfg.base_address = $urandom();
        cfg.stride       = rw_addr_w'($urandom_range(1, 16) * 4);
        cfg.word_count   = rw_count_w'($urandom_range(8, 64));
        // Stray words while idle and during setup
        drive_word($urandom(), 1'b0, '0);
        descriptor_valid = 1'b1;
        next_cycle();
        descriptor_valid = 1'b0;
        while (!config_request) begin
            next_cycle();
        end
        drive_word($urandom(), 1'b0, '0);
        config_valid = 1'b1;
        config_in    = cfg;
        run_open     = 1'b1;
        words_left   = int'(cfg.word_count);
        next_cycle();
        config_valid = 1'b0;
        addr = cfg.base_address;
        for (int seq = 0; seq < int'(cfg.word_count); seq++) begin
            repeat ($urandom_range(0, 3)) next_cycle();
            word = $urandom();
            drive_word(word, 1'b1, expected_request(mode, addr, word));
            // Next word sits one stride further on
            addr = addr + cfg.stride;
        end
        // Words past word_count
        repeat ($urandom_range(1, 2)) begin
            drive_word($urandom(), 1'b0, '0);
        end
        while (!done) begin
            next_cycle();
        end
        next_cycle();
        run_open = 1'b0;
    endtask

    initial begin
        void'($urandom(32));
        areset_generator = 1'b1;
        descriptor_valid = 1'b0;
        config_valid     = 1'b0;
        config_in        = '0;
        engine_valid     = 1'b0;
        engine_data      = '0;
        mem_response_valid = 1'b0;
        mem_response     = '0;
        req_seen  = 1'b0;
        resp_seen = 1'b0;
        word_due  = 1'b0;
        run_open  = 1'b0;
        words_left = 0;
        sync_heads();
        repeat (5) next_cycle();
        areset_generator = 1'b0;
        repeat (3) next_cycle();
        // Write and read runs take turns
        for (int run = 0; run < run_total; run++) begin
            if (run % 2 == 0) begin
                run_once(rw_mode_write);
            end
            else begin
                run_once(rw_mode_read);
            end
            repeat ($urandom_range(2, 6)) next_cycle();
        end
        $display(">>> PASS");
        $finish;
    end

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            fail_run($sformatf("Timeout: the runs did not finish in %0d cycles", timeout_cycles));
        end
    end

    // --------------------
    // Checks
    // --------------------
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        config_request == $past(descriptor_valid))
        else fail_run($sformatf("** Error at time %0t: config_request timing", $time));

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        (busy && !$past(busy)) == $past(config_valid))
        else fail_run($sformatf("** Error at time %0t: busy did not rise after config", $time));

    // Accepted words come out two cycles later and ignored words never
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        mem_request_valid == $past(word_due, 2))
        else fail_run($sformatf("** Error at time %0t: request strobe timing", $time));

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        mem_request_valid |-> (req_pending && mem_request == req_head))
        else fail_run($sformatf("** Error at time %0t: request %h, expected %h",
                                $time, $sampled(mem_request), $sampled(req_head)));

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        engine_response_valid == $past(mem_response_valid))
        else fail_run($sformatf("** Error at time %0t: engine response timing", $time));

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        engine_response_valid |-> (resp_pending && engine_response == resp_head))
        else fail_run($sformatf("** Error at time %0t: engine response %h, expected %h",
                                $time, $sampled(engine_response), $sampled(resp_head)));

    // Done comes once per run after every request is issued and every read is back
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        done |-> (run_open && words_left == 0 && !req_pending && !reads_pending
                  && !resp_pending && !busy && $past(busy)))
        else fail_run($sformatf("** Error at time %0t: done strobe out of place", $time));

endmodule : tb_rw_generator

/* vlog.f */
rw_gen_pkg.sv
rw_request_gen.sv
rw_response_return.sv
rw_control.sv
rw_generator_top.sv
tb_rw_generator.sv
